// ==== vlog.f ====
source/thermal_ffc_pkg.sv
source/calib_ram_1r1w.sv
source/flat_field_capture.sv
source/offset_correction.sv
source/thermal_ffc_top.sv
testbench/tb_thermal_ffc.sv

// ==== Makefile ====
# Verilator build and run for the flat-field correction testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module tb_thermal_ffc \
		-Mdir obj_dir -o tb_thermal_ffc

run: compile
	./obj_dir/tb_thermal_ffc 2>&1 | tee sim.log
	@if grep -q "^sim passed$$" sim.log; then \
		echo "result: PASS"; \
	else \
		echo "result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_thermal_ffc.sv ====
`timescale 1ns/1ps

module tb_thermal_ffc;

    localparam int MAX_ADDR      = 7;
    localparam int AVG_RECIP     = 4096;
    localparam int ADDRW         = thermal_ffc_pkg::ADDRW;
    localparam int NUM_ROWS      = 7;
    localparam int BUSY_TIMEOUT  = 32;
    localparam int DRAIN_TIMEOUT = 8;

    typedef enum logic [1:0] {
        row_capture,
        row_correct
    } row_kind_e;

    // where the unclamped correction sum is meant to land
    typedef enum logic [1:0] {
        rng_any,
        rng_mid,
        rng_low,
        rng_high
    } range_e;

    typedef struct packed {
        row_kind_e               kind;
        logic [ADDRW-1:0]        addr_lo;
        logic [ADDRW-1:0]        addr_hi;
        thermal_ffc_pkg::pixel_t base0;
        thermal_ffc_pkg::pixel_t spread0;
        thermal_ffc_pkg::pixel_t base1;
        thermal_ffc_pkg::pixel_t spread1;
        range_e                  expect_range;
    } row_t;

    logic                         i_clk;
    logic                         i_rst;
    logic                         i_start;
    logic                         i_px_valid;
    thermal_ffc_pkg::pixel_beat_t i_px;
    logic                         o_busy;
    thermal_ffc_pkg::avg_t        o_frame_avg;
    logic                         o_corr_valid;
    thermal_ffc_pkg::corr_beat_t  o_corr;

    row_t rows [NUM_ROWS];

    // reference model state
    thermal_ffc_pkg::pixel_t model_calib [2**ADDRW];
    thermal_ffc_pkg::avg_t   model_avg;
    logic                    cap_active;
    logic                    cap_loading;
    logic                    cap_sp;
    longint                  cap_sum;

    thermal_ffc_pkg::corr_beat_t exp_q [$];
    int                          cyc_q [$];

    int seed;
    int cyc;
    int r;

    thermal_ffc_top #(
        .MAX_ADDR (MAX_ADDR),
        .AVG_RECIP(AVG_RECIP)
    ) u_thermal_ffc_top (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_px_valid  (i_px_valid),
        .i_px        (i_px),
        .o_busy      (o_busy),
        .o_frame_avg (o_frame_avg),
        .o_corr_valid(o_corr_valid),
        .o_corr      (o_corr)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic stop_sim();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at time %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_sim();
        end
    endtask

    task automatic check_avg(input string name, input thermal_ffc_pkg::avg_t got,
                             input thermal_ffc_pkg::avg_t exp);
        if (got !== exp) begin
            $display("error at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            stop_sim();
        end
    endtask

    task automatic check_corr(input string name, input thermal_ffc_pkg::corr_beat_t got,
                              input thermal_ffc_pkg::corr_beat_t exp);
        if (got !== exp) begin
            $display("error at time %0t: %s = addr %0d value %0d, expected addr %0d value %0d",
                     $time, name, got.addr, got.value, exp.addr, exp.value);
            stop_sim();
        end
    endtask

    function automatic thermal_ffc_pkg::pixel_t random_pixel(
        input thermal_ffc_pkg::pixel_t base,
        input thermal_ffc_pkg::pixel_t spread
    );
        return base + (thermal_ffc_pkg::pixel_t'($random(seed)) & spread);
    endfunction

    function automatic thermal_ffc_pkg::pixel_t clamp_pixel(input int v);
        if (v < 0) begin
            return '0;
        end else if (v > 65535) begin
            return '1;
        end
        return thermal_ffc_pkg::pixel_t'(v);
    endfunction

    function automatic range_e range_of(input int v);
        if (v < 0) begin
            return rng_low;
        end else if (v > 65535) begin
            return rng_high;
        end
        return rng_mid;
    endfunction

    // capture rules: wait for the start beat of the current subpage, then
    // store and sum every beat up to the last address
    function automatic void model_capture(input thermal_ffc_pkg::pixel_beat_t b);
        longint prod;
        if (cap_active && !cap_loading) begin
            if ((b.addr == ADDRW'(cap_sp)) && (b.subpage == cap_sp)) begin
                cap_loading = 1'b1;
            end
        end
        if (cap_active && cap_loading) begin
            model_calib[b.addr] = b.data;
            cap_sum = cap_sum + longint'(b.data);
            if (b.addr >= ADDRW'(MAX_ADDR)) begin
                cap_loading = 1'b0;
                if (cap_sp) begin
                    prod = cap_sum * longint'(AVG_RECIP);
                    model_avg = thermal_ffc_pkg::avg_t'(prod >> 16);
                    cap_active = 1'b0;
                end else begin
                    cap_sp = 1'b1;
                end
            end
        end
    endfunction

    // drive one cycle, then look at the outputs on the falling edge
    task automatic tick(input logic valid, input thermal_ffc_pkg::pixel_beat_t beat,
                        input logic start);
        thermal_ffc_pkg::corr_beat_t exp_beat;
        int exp_cyc;
        @(posedge i_clk);
        i_px_valid <= valid;
        i_px       <= beat;
        i_start    <= start;
        cyc = cyc + 1;
        @(negedge i_clk);
        if (o_corr_valid) begin
            if (exp_q.size() == 0) begin
                $display("o_corr_valid high at time %0t with no live beat outstanding", $time);
                stop_sim();
            end else begin
                exp_beat = exp_q.pop_front();
                exp_cyc  = cyc_q.pop_front();
                if (exp_cyc != cyc) begin
                    $display("corrected beat came out at cycle %0d instead of cycle %0d",
                             cyc, exp_cyc);
                    stop_sim();
                end
                check_corr("o_corr", o_corr, exp_beat);
            end
        end
    endtask

    task automatic send_capture_beat(input logic [ADDRW-1:0] addr,
                                     input thermal_ffc_pkg::pixel_t data, input logic sp);
        thermal_ffc_pkg::pixel_beat_t b;
        b.addr    = addr;
        b.data    = data;
        b.subpage = sp;
        model_capture(b);
        tick(1'b1, b, 1'b0);
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (o_busy && (n < BUSY_TIMEOUT)) begin
            tick(1'b0, '0, 1'b0);
            n = n + 1;
        end
        if (o_busy) begin
            $display("timeout: o_busy still high after %0d cycles", n);
            stop_sim();
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0) && (n < DRAIN_TIMEOUT)) begin
            tick(1'b0, '0, 1'b0);
            n = n + 1;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d corrected beats never came out", exp_q.size());
            stop_sim();
        end
    endtask

    task automatic run_capture(input row_t row);
        int a;
        tick(1'b0, '0, 1'b1);
        tick(1'b0, '0, 1'b0);
        check_bit("o_busy", o_busy, 1'b1);
        cap_active  = 1'b1;
        cap_loading = 1'b0;
        cap_sp      = 1'b0;
        cap_sum     = 0;
        // noise before subpage 0, not the start addr and then the wrong subpage bit
        send_capture_beat(ADDRW'(3), random_pixel(row.base0, row.spread0), 1'b0);
        send_capture_beat(ADDRW'(0), random_pixel(row.base0, row.spread0), 1'b1);
        for (a = 0; a <= MAX_ADDR; a++) begin
            send_capture_beat(ADDRW'(a), random_pixel(row.base0, row.spread0), 1'b0);
        end
        // the FSM needs one cycle to go back to searching
        tick(1'b0, '0, 1'b0);
        send_capture_beat(ADDRW'(0), random_pixel(row.base1, row.spread1), 1'b1);
        send_capture_beat(ADDRW'(1), random_pixel(row.base1, row.spread1), 1'b0);
        for (a = 1; a <= MAX_ADDR; a++) begin
            send_capture_beat(ADDRW'(a), random_pixel(row.base1, row.spread1), 1'b1);
        end
        wait_busy_low();
        check_avg("o_frame_avg", o_frame_avg, model_avg);
        // dropped beats would show up here as unexpected outputs
        repeat (3) tick(1'b0, '0, 1'b0);
    endtask

    task automatic run_correct(input int idx, input row_t row);
        int a;
        int sum;
        thermal_ffc_pkg::pixel_t     live;
        thermal_ffc_pkg::pixel_beat_t b;
        thermal_ffc_pkg::corr_beat_t e;
        for (a = int'(row.addr_lo); a <= int'(row.addr_hi); a++) begin
            live      = random_pixel(row.base0, row.spread0);
            b.addr    = ADDRW'(a);
            b.data    = live;
            b.subpage = b.addr[0];
            sum = int'(live) - int'(model_calib[b.addr]) + int'(model_avg);
            if ((row.expect_range != rng_any) && (range_of(sum) != row.expect_range)) begin
                $display("row %0d, addr %0d: stimulus missed the intended clamp range", idx, a);
                stop_sim();
            end
            e.addr  = b.addr;
            e.value = clamp_pixel(sum);
            tick(1'b1, b, 1'b0);
            exp_q.push_back(e);
            cyc_q.push_back(cyc + 2);
        end
        wait_drain();
    endtask

    task automatic load_table();
        // kind, addr_lo, addr_hi, base0, spread0, base1, spread1, range
        rows[0] = '{row_capture, 10'd0, 10'd7, 16'h1000, 16'h0fff, 16'h1000, 16'h0fff, rng_any};
        rows[1] = '{row_correct, 10'd0, 10'd7, 16'h4000, 16'h3fff, 16'h0000, 16'h0000, rng_mid};
        rows[2] = '{row_correct, 10'd0, 10'd7, 16'h0000, 16'hffff, 16'h0000, 16'h0000, rng_any};
        // large subpage 0 and small subpage 1, so avg sits far from most stored values
        rows[3] = '{row_capture, 10'd0, 10'd7, 16'he000, 16'h0fff, 16'h0000, 16'h00ff, rng_any};
        rows[4] = '{row_correct, 10'd0, 10'd0, 16'h0000, 16'h00ff, 16'h0000, 16'h0000, rng_low};
        rows[5] = '{row_correct, 10'd1, 10'd7, 16'hff00, 16'h00ff, 16'h0000, 16'h0000, rng_high};
        rows[6] = '{row_correct, 10'd0, 10'd7, 16'h0000, 16'hffff, 16'h0000, 16'h0000, rng_any};
    endtask

    initial begin
        i_rst       = 1'b1;
        i_start     = 1'b0;
        i_px_valid  = 1'b0;
        i_px        = '0;
        seed        = 74206;
        cyc         = 0;
        model_avg   = '0;
        cap_active  = 1'b0;
        cap_loading = 1'b0;
        cap_sp      = 1'b0;
        cap_sum     = 0;
        load_table();

        repeat (10) @(posedge i_clk);
        i_rst <= 1'b0;
        tick(1'b0, '0, 1'b0);
        check_bit("o_busy", o_busy, 1'b0);
        check_bit("o_corr_valid", o_corr_valid, 1'b0);
        check_avg("o_frame_avg", o_frame_avg, '0);

        for (r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].kind == row_capture) begin
                run_capture(rows[r]);
            end else begin
                run_correct(r, rows[r]);
            end
        end
        repeat (4) tick(1'b0, '0, 1'b0);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== source/thermal_ffc_top.sv ====
`timescale 1ns/1ps

module thermal_ffc_top #(
    parameter int MAX_ADDR  = 767,
    parameter int AVG_RECIP = 85
) (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_start,
    input  logic                         i_px_valid,
    input  thermal_ffc_pkg::pixel_beat_t i_px,
    output logic                         o_busy,
    output thermal_ffc_pkg::avg_t        o_frame_avg,
    output logic                         o_corr_valid,
    output thermal_ffc_pkg::corr_beat_t  o_corr
);
    // calibration read path between correction and capture
    logic                              rd_en;
    logic [thermal_ffc_pkg::ADDRW-1:0] rd_addr;
    thermal_ffc_pkg::pixel_t           rd_data;

    flat_field_capture #(
        .MAX_ADDR (MAX_ADDR),
        .AVG_RECIP(AVG_RECIP)
    ) u_flat_field_capture (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .i_px_valid (i_px_valid),
        .i_px       (i_px),
        .i_rd_en    (rd_en),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (rd_data),
        .o_busy     (o_busy),
        .o_frame_avg(o_frame_avg)
    );

    // correction sees the same sensor stream and stalls on busy
    offset_correction u_offset_correction (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_busy      (o_busy),
        .i_px_valid  (i_px_valid),
        .i_px        (i_px),
        .i_rd_data   (rd_data),
        .i_frame_avg (o_frame_avg),
        .o_rd_en     (rd_en),
        .o_rd_addr   (rd_addr),
        .o_corr_valid(o_corr_valid),
        .o_corr      (o_corr)
    );

endmodule

// ==== source/offset_correction.sv ====
`timescale 1ns/1ps

module offset_correction (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic                              i_busy,
    input  logic                              i_px_valid,
    input  thermal_ffc_pkg::pixel_beat_t      i_px,
    input  thermal_ffc_pkg::pixel_t           i_rd_data,
    input  thermal_ffc_pkg::avg_t             i_frame_avg,
    output logic                              o_rd_en,
    output logic [thermal_ffc_pkg::ADDRW-1:0] o_rd_addr,
    output logic                              o_corr_valid,
    output thermal_ffc_pkg::corr_beat_t       o_corr
);
    localparam int DATAW = thermal_ffc_pkg::DATAW;

    // live - calib + avg ranges over -98303..98302, so two extra bits
    localparam int CALCW = DATAW + 2;

    logic                         accept;
    logic                         s1_valid;
    thermal_ffc_pkg::pixel_beat_t s1_px;
    logic signed [CALCW-1:0]      calc;
    thermal_ffc_pkg::pixel_t      clamped;

    // live beats are dropped while a capture runs
    assign accept = i_px_valid && !i_busy;

    // stage 1: read the calibration word for this address
    assign o_rd_en   = accept;
    assign o_rd_addr = i_px.addr;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_px <= i_px;
    end

    // stage 2: offset removal and clamp
    always_comb begin
        calc = $signed({2'b00, s1_px.data})
             - $signed({2'b00, i_rd_data})
             + CALCW'(i_frame_avg);
        if (calc[CALCW-1]) begin
            // negative result
            clamped = '0;
        end else if (calc[CALCW-2:DATAW] != '0) begin
            clamped = '1;
        end else begin
            clamped = calc[DATAW-1:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_corr_valid <= 1'b0;
        end else begin
            o_corr_valid <= s1_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_corr.addr  <= s1_px.addr;
        o_corr.value <= clamped;
    end

    // RAM read plus result register give a fixed two-cycle latency
    a_corr_latency: assert property (@(posedge i_clk) disable iff (i_rst)
        accept |-> ##2 o_corr_valid);

endmodule

// ==== source/flat_field_capture.sv ====
`timescale 1ns/1ps

module flat_field_capture #(
    parameter int MAX_ADDR  = 767,
    parameter int AVG_RECIP = 85
) (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic                              i_start,
    input  logic                              i_px_valid,
    input  thermal_ffc_pkg::pixel_beat_t      i_px,
    input  logic                              i_rd_en,
    input  logic [thermal_ffc_pkg::ADDRW-1:0] i_rd_addr,
    output thermal_ffc_pkg::pixel_t           o_rd_data,
    output logic                              o_busy,
    output thermal_ffc_pkg::avg_t             o_frame_avg
);
    localparam int DATAW = thermal_ffc_pkg::DATAW;
    localparam int ADDRW = thermal_ffc_pkg::ADDRW;

    // two subpages of up to MAX_ADDR+1 pixels each
    localparam int SUMW = DATAW + $clog2(MAX_ADDR + 1) + 1;

    // sum times a Q0.16 reciprocal of up to 16 bits
    localparam int PRODW = SUMW + 17;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_frame,
        st_load_frame
    } state_e;

    typedef struct packed {
        state_e                state;
        logic                  subpage;
        logic [SUMW-1:0]       pixel_sum;
        thermal_ffc_pkg::avg_t frame_avg;
    } ctrl_t;

    localparam ctrl_t CTRL_RST = '{
        state:     st_idle,
        subpage:   1'b0,
        pixel_sum: '0,
        frame_avg: '0
    };

    ctrl_t r;
    ctrl_t r_next;

    // input beat, registered once
    logic                         r_px_valid;
    thermal_ffc_pkg::pixel_beat_t r_px;

    logic             ram_we;
    logic             start_hit;
    logic [SUMW-1:0]  sum_next;
    logic [PRODW-1:0] avg_prod;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_px_valid <= 1'b0;
        end else begin
            r_px_valid <= i_px_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        r_px <= i_px;
    end

    // a subpage frame opens on the beat whose addr equals its subpage bit
    assign start_hit = i_px_valid
                    && (i_px.addr == ADDRW'(r.subpage))
                    && (i_px.subpage == r.subpage);

    assign ram_we = (r.state == st_load_frame) && r_px_valid;

    // running sum including the beat being written this cycle
    assign sum_next = r.pixel_sum + SUMW'(r_px.data);

    // average = sum * recip >> 16, the last beat already folded in
    assign avg_prod = PRODW'(sum_next) * PRODW'(AVG_RECIP);

    always_comb begin
        r_next = r;
        case (r.state)
            st_idle: begin
                if (i_start) begin
                    r_next.state     = st_wait_frame;
                    r_next.subpage   = 1'b0;
                    r_next.pixel_sum = '0;
                end
            end
            st_wait_frame: begin
                if (start_hit) begin
                    r_next.state = st_load_frame;
                end
            end
            st_load_frame: begin
                if (r_px_valid) begin
                    r_next.pixel_sum = sum_next;
                    // last pixel of this subpage frame
                    if (r_px.addr >= ADDRW'(MAX_ADDR)) begin
                        if (r.subpage) begin
                            r_next.state     = st_idle;
                            r_next.frame_avg = avg_prod[16 +: DATAW];
                        end else begin
                            r_next.state   = st_wait_frame;
                            r_next.subpage = 1'b1;
                        end
                    end
                end
            end
            default: begin
                r_next = CTRL_RST;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r <= CTRL_RST;
        end else begin
            r <= r_next;
        end
    end

    assign o_busy      = (r.state != st_idle);
    assign o_frame_avg = r.frame_avg;

    // calibration store, written from the registered beat
    calib_ram_1r1w #(
        .DW(DATAW),
        .AW(ADDRW)
    ) u_calib_ram (
        .i_clk  (i_clk),
        .i_we   (ram_we),
        .i_waddr(r_px.addr),
        .i_wdata(r_px.data),
        .i_re   (i_rd_en),
        .i_raddr(i_rd_addr),
        .o_rdata(o_rd_data)
    );

    // a write follows a beat that opened the frame or arrived while loading
    a_write_in_load: assert property (@(posedge i_clk) disable iff (i_rst)
        ram_we |-> $past(start_hit || ((r.state == st_load_frame) && i_px_valid)));

    // idle without a start pulse keeps busy low on the next cycle
    a_idle_not_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        (r.state == st_idle) && !i_start |=> !o_busy);

endmodule

// ==== source/calib_ram_1r1w.sv ====
`timescale 1ns/1ps

module calib_ram_1r1w #(
    parameter int DW = 16,
    parameter int AW = 10
) (
    input  logic          i_clk,
    input  logic          i_we,
    input  logic [AW-1:0] i_waddr,
    input  logic [DW-1:0] i_wdata,
    input  logic          i_re,
    input  logic [AW-1:0] i_raddr,
    output logic [DW-1:0] o_rdata
);
    // full address space of the write port
    localparam int DEPTH = 2 ** AW;

    logic [DW-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, output holds between reads
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

// ==== source/thermal_ffc_pkg.sv ====
package thermal_ffc_pkg;

    // pixel value width as delivered by the sensor
    localparam int DATAW = 16;

    // 10 bits cover the 768 pixels of a 32x24 frame
    localparam int ADDRW = 10;

    // raw or corrected pixel value, always unsigned
    typedef logic [DATAW-1:0] pixel_t;

    // frame average, signed so it can enter the offset sum directly
    typedef logic signed [DATAW-1:0] avg_t;

    // one sensor beat
    typedef struct packed {
        logic [ADDRW-1:0] addr;
        pixel_t           data;
        logic             subpage;
    } pixel_beat_t;

    // one corrected output beat
    typedef struct packed {
        logic [ADDRW-1:0] addr;
        pixel_t           value;
    } corr_beat_t;

endpackage
